// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Isource
TOP       ?= tb_ib_top
FILELIST  ?= filelist.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard source/*.svh)
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+source
source/ib_pkg.sv
source/ib_valid_ctl.sv
source/ib_slot_array.sv
source/dbg_inst_gen.sv
source/ib_top.sv
testbench/tb_clock_gen.sv
testbench/tb_ib_top.sv

// ==== source/dbg_inst_gen.sv ====
`default_nettype none

`include "ib_params.svh"

module dbg_inst_gen (
   input  logic             clk,
   input  logic             rst_n,
   input  ib_pkg::dbg_cmd_t dbg_cmd,
   output logic             dbg_valid,
   output logic [`XLEN-1:0] dbg_instr,
   output logic             debug_wdata_rs1,
   output logic             debug_fence
);

   logic        is_gpr;
   logic        is_csr;
   logic        rd_gpr;
   logic        wr_gpr;
   logic        rd_csr;
   logic        wr_csr;
   logic        fence_in;
   logic [4:0]  dreg;
   logic [11:0] dcsr;

   // memory commands never enter the buffer
   assign dbg_valid = dbg_cmd.valid & (dbg_cmd.cmd_type != `DBG_TYPE_MEM);

   assign is_gpr = dbg_cmd.cmd_type == `DBG_TYPE_GPR;
   assign is_csr = dbg_cmd.cmd_type == `DBG_TYPE_CSR;

   assign rd_gpr = dbg_valid & ~dbg_cmd.write & is_gpr;
   assign wr_gpr = dbg_valid &  dbg_cmd.write & is_gpr;
   assign rd_csr = dbg_valid & ~dbg_cmd.write & is_csr;
   assign wr_csr = dbg_valid &  dbg_cmd.write & is_csr;

   assign dreg = dbg_cmd.addr.gpr.regno;
   assign dcsr = dbg_cmd.addr.csr.csrno;

   // reads put the source on rs1 via or/csrrs
   // writes take their data from rs1 in the next cycle
   assign dbg_instr =
      ({`XLEN{rd_gpr}} & `INST_R_OR(`REG_X0, dreg)) |   // or x0, reg, x0
      ({`XLEN{wr_gpr}} & `INST_R_OR(dreg, `REG_X0)) |   // or reg, x0, x0
      ({`XLEN{rd_csr}} & `INST_CSR(dcsr, `F3_CSRRS)) |  // csrrs x0, csr, x0
      ({`XLEN{wr_csr}} & `INST_CSR(dcsr, `F3_CSRRW));   // csrrw x0, csr, x0

   assign fence_in = wr_csr & (dcsr == `DBG_FENCE_CSR);

   // pipe is empty in halt, so the write reaches decode one cycle later
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         debug_wdata_rs1 <= 1'b0;
         debug_fence     <= 1'b0;
      end else begin
         debug_wdata_rs1 <= wr_gpr | wr_csr;
         debug_fence     <= fence_in;
      end
   end

endmodule

`default_nettype wire

// ==== source/ib_params.svh ====
`ifndef IB_PARAMS_SVH
`define IB_PARAMS_SVH

// buffer geometry
`define IB_DEPTH 4
`define XLEN     32
`define PC_W     31           // pc[31:1] as bit 0 is always zero

// debug command type field
`define DBG_TYPE_GPR 2'd0
`define DBG_TYPE_CSR 2'd1
`define DBG_TYPE_MEM 2'd2     // abstract memory access served elsewhere

// debug-only fence reached through a csr write
`define DBG_FENCE_CSR 12'h7c4

// encoding fields
`define OPC_OP     7'h33
`define OPC_SYSTEM 7'h73
`define F3_OR      3'd6
`define F3_CSRRW   3'd1
`define F3_CSRRS   3'd2
`define REG_X0     5'd0

// or rd, rs1, x0
`define INST_R_OR(rd, rs1) {7'd0, `REG_X0, rs1, `F3_OR, rd, `OPC_OP}

// csr op with x0 as rd and rs1
`define INST_CSR(csr, f3) {csr, `REG_X0, f3, `REG_X0, `OPC_SYSTEM}

`endif

// ==== source/ib_pkg.sv ====
`default_nettype none

`include "ib_params.svh"

package ib_pkg;

   // fault flags that ride along with each instruction
   typedef struct packed {
      logic icaf;             // access fault
      logic icaf_second;      // fault on the upper half of a 4B inst
      logic perr;             // icache parity error
      logic sbecc;
      logic dbecc;
   } ib_fault_t;

   // one buffer slot
   typedef struct packed {
      logic [`XLEN-1:0] instr;
      logic [`PC_W-1:0] pc;
      logic             pc4;  // 4B inst when set
      ib_fault_t        fault;
   } ib_entry_t;

   typedef struct packed {
      logic      valid;
      ib_entry_t entry;
   } fetch_pkt_t;

   // the debug address is a gpr number or a csr number
   typedef struct packed {
      logic [26:0] pad;
      logic [4:0]  regno;
   } dbg_gpr_view_t;

   typedef struct packed {
      logic [19:0] pad;
      logic [11:0] csrno;
   } dbg_csr_view_t;

   typedef union packed {
      dbg_gpr_view_t gpr;
      dbg_csr_view_t csr;
   } dbg_addr_u;

   typedef struct packed {
      logic      valid;
      logic      write;       // 1 write, 0 read
      logic [1:0] cmd_type;   // gpr, csr or mem
      dbg_addr_u addr;
   } dbg_cmd_t;

   // slot controls for one cycle
   typedef struct packed {
      logic [3:0] i0_wr;      // i0 lands in slot n
      logic [3:1] i1_wr;      // i1 lands in slot n
      logic [3:1] sh1;        // slot n moves to n-1
      logic [3:2] sh2;        // slot n moves to n-2
   } ib_sel_t;

endpackage

`default_nettype wire

// ==== source/ib_slot_array.sv ====
`default_nettype none

`include "ib_params.svh"

module ib_slot_array (
   input  logic              clk,
   input  logic              rst_n,
   input  ib_pkg::ib_sel_t   sel,
   input  ib_pkg::ib_entry_t i0_entry,
   input  ib_pkg::ib_entry_t i1_entry,
   input  logic              dbg_valid,
   input  logic [`XLEN-1:0]  dbg_instr,
   output ib_pkg::ib_entry_t dec_i0,
   output ib_pkg::ib_entry_t dec_i1
);

   ib_pkg::ib_entry_t    slot_q [`IB_DEPTH];
   ib_pkg::ib_entry_t    slot_d [`IB_DEPTH];
   ib_pkg::ib_entry_t    i0_head;         // i0 as seen by slot 0
   logic [`IB_DEPTH-1:0] wen;

   function automatic ib_pkg::ib_entry_t pick(input logic en, input ib_pkg::ib_entry_t e);
      return en ? e : '0;
   endfunction

   // debug commands replace only the instruction word
   always_comb begin
      i0_head = i0_entry;
      if (dbg_valid) begin
         i0_head.instr = dbg_instr;
      end
   end

   always_comb begin
      slot_d[0] = pick(sel.i0_wr[0], i0_head) |
                  pick(sel.sh1[1], slot_q[1]) |
                  pick(sel.sh2[2], slot_q[2]);
      slot_d[1] = pick(sel.i0_wr[1], i0_entry) |
                  pick(sel.i1_wr[1], i1_entry) |
                  pick(sel.sh1[2], slot_q[2]) |
                  pick(sel.sh2[3], slot_q[3]);
      slot_d[2] = pick(sel.i0_wr[2], i0_entry) |
                  pick(sel.i1_wr[2], i1_entry) |
                  pick(sel.sh1[3], slot_q[3]);
      slot_d[3] = pick(sel.i0_wr[3], i0_entry) |
                  pick(sel.i1_wr[3], i1_entry);
   end

   assign wen[0] = sel.i0_wr[0] | sel.sh1[1] | sel.sh2[2];
   assign wen[1] = sel.i0_wr[1] | sel.i1_wr[1] | sel.sh1[2] | sel.sh2[3];
   assign wen[2] = sel.i0_wr[2] | sel.i1_wr[2] | sel.sh1[3];
   assign wen[3] = sel.i0_wr[3] | sel.i1_wr[3];

   always_ff @(posedge clk) begin
      for (int i = 0; i < `IB_DEPTH; i++) begin
         if (!rst_n) begin
            slot_q[i] <= '0;
         end else if (wen[i]) begin
            slot_q[i] <= slot_d[i];
         end
      end
   end

   assign dec_i0 = slot_q[0];
   assign dec_i1 = slot_q[1];

   // the or-mux needs exclusive selects per slot
   a_one_src: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({sel.i0_wr[0], sel.sh1[1], sel.sh2[2]}) &&
      $onehot0({sel.i0_wr[1], sel.i1_wr[1], sel.sh1[2], sel.sh2[3]}) &&
      $onehot0({sel.i0_wr[2], sel.i1_wr[2], sel.sh1[3]}) &&
      $onehot0({sel.i0_wr[3], sel.i1_wr[3]}))
      else $error("more than one source into a slot");

   // core is halted for debug, so slot 0 must be free to take the command
   a_dbg_head: assert property (@(posedge clk) disable iff (!rst_n)
      dbg_valid |-> sel.i0_wr[0])
      else $error("debug command while slot 0 occupied");

endmodule

`default_nettype wire

// ==== source/ib_top.sv ====
`default_nettype none

`include "ib_params.svh"

module ib_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,
   input  ib_pkg::fetch_pkt_t   i0_fetch,
   input  ib_pkg::fetch_pkt_t   i1_fetch,
   input  logic                 i0_decode,
   input  logic                 i1_decode,
   input  ib_pkg::dbg_cmd_t     dbg_cmd,
   output logic [`IB_DEPTH-1:0] ib_valid,
   output ib_pkg::ib_entry_t    dec_i0,
   output ib_pkg::ib_entry_t    dec_i1,
   output logic                 debug_wdata_rs1,
   output logic                 debug_fence
);

   ib_pkg::ib_sel_t  sel;         // per-cycle slot moves
   logic             dbg_valid;
   logic [`XLEN-1:0] dbg_instr;

   // valid bits, flush and room check
   ib_valid_ctl u_valid_ctl (
      .clk            (clk),
      .rst_n          (rst_n),
      .flush          (flush),
      .i0_fetch_valid (i0_fetch.valid),
      .i1_fetch_valid (i1_fetch.valid),
      .i0_decode      (i0_decode),
      .i1_decode      (i1_decode),
      .dbg_valid      (dbg_valid),
      .sel            (sel),
      .ib_valid       (ib_valid)
   );

   ib_slot_array u_slot_array (
      .clk       (clk),
      .rst_n     (rst_n),
      .sel       (sel),
      .i0_entry  (i0_fetch.entry),
      .i1_entry  (i1_fetch.entry),
      .dbg_valid (dbg_valid),
      .dbg_instr (dbg_instr),
      .dec_i0    (dec_i0),
      .dec_i1    (dec_i1)
   );

   // debug gpr/csr access becomes an instruction in slot 0
   dbg_inst_gen u_dbg_inst_gen (
      .clk             (clk),
      .rst_n           (rst_n),
      .dbg_cmd         (dbg_cmd),
      .dbg_valid       (dbg_valid),
      .dbg_instr       (dbg_instr),
      .debug_wdata_rs1 (debug_wdata_rs1),
      .debug_fence     (debug_fence)
   );

endmodule

`default_nettype wire

// ==== source/ib_valid_ctl.sv ====
`default_nettype none

`include "ib_params.svh"

module ib_valid_ctl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,
   input  logic                 i0_fetch_valid,
   input  logic                 i1_fetch_valid,
   input  logic                 i0_decode,
   input  logic                 i1_decode,
   input  logic                 dbg_valid,
   output ib_pkg::ib_sel_t      sel,
   output logic [`IB_DEPTH-1:0] ib_valid
);

   logic                 flush_q;
   logic [`IB_DEPTH-1:0] ibval;
   logic [`IB_DEPTH-1:0] ibval_in;
   logic [`IB_DEPTH-1:0] ibval_wr;       // old valids plus this cycle's writes
   logic [`IB_DEPTH-1:0] shift_ibval;    // old valids after decode shift
   logic [`IB_DEPTH-1:0] i0_wen;
   logic [`IB_DEPTH-1:1] i1_wen;
   logic                 shift0;
   logic                 shift1;
   logic                 shift2;
   logic                 i0_take;
   logic                 i1_take;

   assign shift0 = ~i0_decode;
   assign shift1 = i0_decode & ~i1_decode;
   assign shift2 = i0_decode & i1_decode;

   // room check on the current state only
   assign i0_take = i0_fetch_valid & ~ibval[3] & ~flush_q;
   assign i1_take = i1_fetch_valid & ~ibval[2] & ~flush_q;

   // write positions in the unshifted frame for valid tracking
   assign i0_wen[0] = ~ibval[0] & (i0_take | dbg_valid);
   assign i0_wen[1] = ibval[0] & ~ibval[1] & i0_take;
   assign i0_wen[2] = ibval[1] & ~ibval[2] & i0_take;
   assign i0_wen[3] = ibval[2] & ~ibval[3] & i0_take;

   assign i1_wen[1] = ~ibval[0] & i1_take;
   assign i1_wen[2] = ibval[0] & ~ibval[1] & i1_take;
   assign i1_wen[3] = ibval[1] & ~ibval[2] & i1_take;

   assign ibval_wr = ibval | i0_wen | {i1_wen, 1'b0};

   assign ibval_in = (({`IB_DEPTH{shift0}} & ibval_wr) |
                      ({`IB_DEPTH{shift1}} & {1'b0, ibval_wr[3:1]}) |
                      ({`IB_DEPTH{shift2}} & {2'b0, ibval_wr[3:2]})) &
                     ~{`IB_DEPTH{flush_q}};

   assign shift_ibval = ({`IB_DEPTH{shift0}} & ibval) |
                        ({`IB_DEPTH{shift1}} & {1'b0, ibval[3:1]}) |
                        ({`IB_DEPTH{shift2}} & {2'b0, ibval[3:2]});

   // data moves put writes in the first free slot after the shift
   always_comb begin
      sel.i0_wr[0] = ~shift_ibval[0] & (i0_take | dbg_valid);
      sel.i0_wr[1] = shift_ibval[0] & ~shift_ibval[1] & i0_take;
      sel.i0_wr[2] = shift_ibval[1] & ~shift_ibval[2] & i0_take;
      sel.i0_wr[3] = shift_ibval[2] & ~shift_ibval[3] & i0_take;

      sel.i1_wr[1] = ~shift_ibval[0] & i1_take;
      sel.i1_wr[2] = shift_ibval[0] & ~shift_ibval[1] & i1_take;
      sel.i1_wr[3] = shift_ibval[1] & ~shift_ibval[2] & i1_take;

      sel.sh1[1] = shift1 & ibval[1];
      sel.sh1[2] = shift1 & ibval[2];
      sel.sh1[3] = shift1 & ibval[3];
      sel.sh2[2] = shift2 & ibval[2];
      sel.sh2[3] = shift2 & ibval[3];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flush_q <= 1'b0;
         ibval   <= '0;
      end else begin
         flush_q <= flush;
         ibval   <= ibval_in;
      end
   end

   assign ib_valid = ibval;

   // occupied slots always form a run from slot 0
   a_contig: assert property (@(posedge clk) disable iff (!rst_n)
      (ibval & (ibval + 1'b1)) == '0)
      else $error("ib valids not contiguous: %b", ibval);

   a_dec_order: assert property (@(posedge clk) disable iff (!rst_n)
      i1_decode |-> i0_decode)
      else $error("i1 decoded without i0");

   a_dec_full: assert property (@(posedge clk) disable iff (!rst_n)
      i0_decode |-> ibval[0] && (!i1_decode || ibval[1]))
      else $error("decode of an empty slot, valids %b", ibval);

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_PERIOD = 5;   // 10 ns clock
   localparam int RST_CYCLES  = 8;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // release just after an edge so the first sampled edge sees a clean rst_n
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_ib_top.sv ====
`default_nettype none

`include "ib_params.svh"

module tb_ib_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NROWS      = 34;
   localparam int RST_CYCLES = 8;
   localparam int CLK_PERIOD = 10;

   typedef struct packed {
      logic        flush;
      logic        f0;          // i0 fetch valid
      logic        f1;          // i1 fetch valid
      logic        d0;          // i0_decode
      logic        d1;          // i1_decode
      logic        dv;          // debug command valid
      logic        dw;          // debug write
      logic [1:0]  dt;          // debug type
      logic [11:0] da;          // debug address
      logic [2:0]  cnt;         // expected valid count after the edge
   } stim_row_t;

   logic                 clk;
   logic                 rst_n;
   logic                 flush;
   ib_pkg::fetch_pkt_t   i0_fetch;
   ib_pkg::fetch_pkt_t   i1_fetch;
   logic                 i0_decode;
   logic                 i1_decode;
   ib_pkg::dbg_cmd_t     dbg_cmd;
   logic [`IB_DEPTH-1:0] ib_valid;
   ib_pkg::ib_entry_t    dec_i0;
   ib_pkg::ib_entry_t    dec_i1;
   logic                 debug_wdata_rs1;
   logic                 debug_fence;

   stim_row_t         stim [NROWS];
   ib_pkg::ib_entry_t model_q [$];   // oldest entry at the front
   ib_pkg::ib_entry_t cur_e0;
   ib_pkg::ib_entry_t cur_e1;
   logic              model_flush_q;
   logic              exp_wdata;
   logic              exp_fence;
   integer            seed = 71;

   tb_clock_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   ib_top uut (
      .clk             (clk),
      .rst_n           (rst_n),
      .flush           (flush),
      .i0_fetch        (i0_fetch),
      .i1_fetch        (i1_fetch),
      .i0_decode       (i0_decode),
      .i1_decode       (i1_decode),
      .dbg_cmd         (dbg_cmd),
      .ib_valid        (ib_valid),
      .dec_i0          (dec_i0),
      .dec_i1          (dec_i1),
      .debug_wdata_rs1 (debug_wdata_rs1),
      .debug_fence     (debug_fence)
   );

   task automatic fill_stim();
      // fl  f0  f1  d0  d1  dv  dw  type  addr  count
      stim[0]  = '{0, 1, 1, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd2};  // dual fetch
      stim[1]  = '{0, 1, 1, 1, 1, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd2};
      stim[2]  = '{0, 1, 1, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd3};
      stim[3]  = '{0, 1, 1, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd4};  // i1 has no room
      stim[4]  = '{0, 1, 1, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd4};  // full
      stim[5]  = '{0, 1, 1, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd3};
      stim[6]  = '{0, 1, 1, 1, 1, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd2};
      stim[7]  = '{0, 1, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd2};
      stim[8]  = '{0, 0, 0, 1, 1, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
      stim[9]  = '{0, 1, 1, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd2};
      stim[10] = '{0, 1, 1, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd4};
      stim[11] = '{0, 0, 0, 1, 1, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd2};
      stim[12] = '{0, 0, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd1};
      stim[13] = '{0, 1, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd1};
      stim[14] = '{0, 1, 1, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd2};
      stim[15] = '{1, 1, 1, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd4};  // flush raised
      stim[16] = '{0, 1, 1, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};  // fetch lost
      stim[17] = '{0, 1, 0, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd1};
      stim[18] = '{1, 0, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
      stim[19] = '{0, 1, 1, 0, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
      stim[20] = '{0, 0, 0, 0, 0, 1, 0, `DBG_TYPE_GPR, 12'h005, 3'd1};  // gpr read x5
      stim[21] = '{0, 0, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
      stim[22] = '{0, 0, 0, 0, 0, 1, 1, `DBG_TYPE_GPR, 12'h01f, 3'd1};  // gpr write x31
      stim[23] = '{0, 0, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
      stim[24] = '{0, 0, 0, 0, 0, 1, 0, `DBG_TYPE_CSR, 12'h300, 3'd1};  // csr read
      stim[25] = '{0, 0, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
      stim[26] = '{0, 0, 0, 0, 0, 1, 1, `DBG_TYPE_CSR, 12'h7c4, 3'd1};  // fence csr
      stim[27] = '{0, 0, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
      stim[28] = '{0, 0, 0, 0, 0, 1, 1, `DBG_TYPE_CSR, 12'h305, 3'd1};  // csr write
      stim[29] = '{0, 0, 0, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
      stim[30] = '{0, 0, 0, 0, 0, 1, 1, `DBG_TYPE_MEM, 12'h7c4, 3'd0};  // ignored
      stim[31] = '{0, 0, 0, 0, 0, 1, 1, `DBG_TYPE_GPR, 12'h7c4, 3'd1};  // reg x4 without fence
      stim[32] = '{0, 1, 1, 1, 0, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd2};
      stim[33] = '{0, 0, 0, 1, 1, 0, 0, `DBG_TYPE_GPR, 12'h000, 3'd0};
   endtask

   task automatic check_val(input string name, input logic [127:0] act,
                            input logic [127:0] exp);
      if (act !== exp) begin
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, act, exp);
         $display("TB FAILED");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic make_entry(output ib_pkg::ib_entry_t e);
      logic [31:0] r;
      r = $random(seed);
      e.instr = r;
      r = $random(seed);
      e.pc  = r[30:0];
      e.pc4 = r[31];
      r = $random(seed);
      e.fault = r[4:0];
   endtask

   // instruction word that a debug command should turn into
   function automatic logic [31:0] encode_dbg(input stim_row_t row);
      logic [4:0]  regno;
      logic [11:0] csr;
      regno = row.da[4:0];
      csr   = row.da;
      if (row.dt == `DBG_TYPE_CSR) begin
         if (row.dw)
            return {csr, 5'd0, 3'b001, 5'd0, 7'b1110011};     // csrrw x0, csr, x0
         return {csr, 5'd0, 3'b010, 5'd0, 7'b1110011};        // csrrs x0, csr, x0
      end
      if (row.dw)
         return {7'd0, 5'd0, 5'd0, 3'b110, regno, 7'b0110011}; // or reg, x0, x0
      return {7'd0, 5'd0, regno, 3'b110, 5'd0, 7'b0110011};    // or x0, reg, x0
   endfunction

   task automatic drive_row(input stim_row_t row);
      make_entry(cur_e0);
      make_entry(cur_e1);
      flush          = row.flush;
      i0_fetch.valid = row.f0;
      i0_fetch.entry = cur_e0;
      i1_fetch.valid = row.f1;
      i1_fetch.entry = cur_e1;
      i0_decode      = row.d0;
      i1_decode      = row.d1;
      dbg_cmd.valid    = row.dv;
      dbg_cmd.write    = row.dw;
      dbg_cmd.cmd_type = row.dt;
      dbg_cmd.addr     = {20'd0, row.da};
   endtask

   // queue model for one rising edge
   task automatic model_step(input stim_row_t row);
      int                n;
      logic              take0;
      logic              take1;
      logic              dbg_in;
      ib_pkg::ib_entry_t de;
      n      = model_q.size();
      take0  = row.f0 && (n < 4) && !model_flush_q;   // room seen before the shift
      take1  = row.f1 && (n < 3) && !model_flush_q;
      dbg_in = row.dv && (row.dt != `DBG_TYPE_MEM);
      if (row.d0)
         void'(model_q.pop_front());
      if (row.d1)
         void'(model_q.pop_front());
      if (dbg_in) begin
         de       = cur_e0;
         de.instr = encode_dbg(row);
         model_q.push_back(de);
      end else begin
         if (take0)
            model_q.push_back(cur_e0);
         if (take1)
            model_q.push_back(cur_e1);
      end
      if (model_flush_q)
         model_q.delete();
      model_flush_q = row.flush;
      exp_wdata = dbg_in && row.dw;
      exp_fence = dbg_in && row.dw && (row.dt == `DBG_TYPE_CSR) && (row.da == 12'h7c4);
   endtask

   task automatic check_outputs(input stim_row_t row);
      int                   n;
      logic [`IB_DEPTH-1:0] exp_valid;
      n         = model_q.size();
      exp_valid = '0;
      for (int i = 0; i < n; i++)
         exp_valid[i] = 1'b1;
      check_val("ib_valid", 128'(ib_valid), 128'(exp_valid));
      check_val("ib_valid count", 128'($countones(ib_valid)), 128'(row.cnt));
      if (n > 0)
         check_val("dec_i0", 128'(dec_i0), 128'(model_q[0]));
      if (n > 1)
         check_val("dec_i1", 128'(dec_i1), 128'(model_q[1]));
      check_val("debug_wdata_rs1", 128'(debug_wdata_rs1), 128'(exp_wdata));
      check_val("debug_fence", 128'(debug_fence), 128'(exp_fence));
   endtask

   initial begin
      flush         = 1'b0;
      i0_fetch      = '0;
      i1_fetch      = '0;
      i0_decode     = 1'b0;
      i1_decode     = 1'b0;
      dbg_cmd       = '0;
      model_flush_q = 1'b0;
      exp_wdata     = 1'b0;
      exp_fence     = 1'b0;
      fill_stim();
      @(posedge rst_n);
      check_val("ib_valid", 128'(ib_valid), 128'(0));
      check_val("dec_i0", 128'(dec_i0), 128'(0));
      check_val("dec_i1", 128'(dec_i1), 128'(0));
      check_val("debug_wdata_rs1", 128'(debug_wdata_rs1), 128'(0));
      check_val("debug_fence", 128'(debug_fence), 128'(0));
      for (int r = 0; r < NROWS; r++) begin
         drive_row(stim[r]);          // 1 ns after the edge
         @(posedge clk);
         model_step(stim[r]);
         #1;
         check_outputs(stim[r]);
      end
      $display("TB PASSED");
      $finish;
   end

   // reset plus a generous budget per table row
   initial begin
      #((RST_CYCLES + NROWS * 20) * CLK_PERIOD);
      $display("timeout: the stimulus table did not finish in time");
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire
